// ==== verilog/memPkg.sv ====
// Shared widths of the memory front end
// Bit positions of the VMA flags word
// Decoded microword and processor flag structs

`default_nettype none

package memPkg;

   ////////////////////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////////////////////

   // Virtual address, word and flag widths
   localparam int addrWidth = 22;
   localparam int dataWidth = 36;
   localparam int flagWidth = 14;

   ////////////////////////////////////////////////////////////////////////////
   // Flag positions, bit 0 is the leftmost bit
   ////////////////////////////////////////////////////////////////////////////

   // Bits 1 and 6 are unused and read as zero
   localparam int flagUser     = 0;
   localparam int flagFetch    = 2;
   localparam int flagRead     = 3;
   localparam int flagWrTest   = 4;
   localparam int flagWrite    = 5;
   localparam int flagCacheInh = 7;
   localparam int flagPhysical = 8;
   localparam int flagPrevious = 9;
   localparam int flagIo       = 10;
   localparam int flagWru      = 11;
   localparam int flagVector   = 12;
   localparam int flagIoByte   = 13;

   ////////////////////////////////////////////////////////////////////////////
   // Decoded microword
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic cycle;        // Memory function enable
      logic loadVma;      // Load VMA from datapath
      logic aRead;        // Cycle type from dispatch
      logic dpFunc;       // Flags taken from datapath word
      logic fetchCycle;
      logic physical;
      logic readCycle;
      logic wrTestCycle;
      logic writeCycle;
      logic cacheInh;
      logic forceUser;
      logic forceExec;
      logic extAddr;
      logic clrCache;     // Cache sweep request
      logic selPrevious;  // Previous context select
      // Dispatch ROM outputs
      logic dispVma;
      logic dispRead;
      logic dispWrTest;
      logic dispWrite;
   } memCmd_t;

   // Processor state flags seen by the VMA logic
   typedef struct packed {
      logic user;
      logic prevUser;
   } pcFlags_t;

endpackage

`default_nettype wire

// ==== verilog/memIf.sv ====
// Interface between the memory controller and the VMA datapath
// Modports for the controller, the VMA register and the cycle register

`default_nettype none

interface vmaIf #(
   parameter int addrWidth = memPkg::addrWidth
);

   // From the controller
   memPkg::memCmd_t cmd;
   logic loadStrobe;

   // VMA register outputs
   logic [addrWidth-1:0] vmaAddr;
   logic [0:memPkg::flagWidth-1] vmaFlags;

   // Cycle register outputs
   logic rdCycle;
   logic wrTestCycle;
   logic wrCycle;
   logic cacheInh;
   logic [0:memPkg::dataWidth-1] writeData;

   modport ctrl (output cmd, loadStrobe,
                 input vmaAddr, rdCycle, wrTestCycle, wrCycle, writeData);

   modport vma (input cmd, loadStrobe, rdCycle, wrTestCycle, wrCycle, cacheInh,
                output vmaAddr, vmaFlags);

   modport cycle (input cmd, loadStrobe,
                  output rdCycle, wrTestCycle, wrCycle, cacheInh, writeData);

endinterface

`default_nettype wire

// ==== verilog/vmaRegister.sv ====
// Virtual memory address register
// User, fetch, physical, previous and I/O access flags
// Assembly of the 14-bit VMA flags word

`default_nettype none

module vmaRegister #(
   parameter int addrWidth = memPkg::addrWidth
)
(
   input  wire logic                         clk,
   input  wire logic                         rst,
   vmaIf.vma                                 vmaBus,
   input  wire logic [0:memPkg::dataWidth-1] dp,
   input  wire memPkg::pcFlags_t             pcFlags,
   input  wire logic                         cpuExec,
   input  wire logic                         prevEn,
   output logic                              vmaSweep,
   output logic                              vmaExtended
);

   logic loadEn;
   logic userNext;
   logic [addrWidth-1:0] addrReg;
   logic user;
   logic fetch;
   logic physical;
   logic previous;
   logic ioCycle;
   logic wruCycle;
   logic vectorCycle;
   logic ioByteCycle;
   logic [0:memPkg::flagWidth-1] flags;

   ////////////////////////////////////////////////////////////////////////////
   // Load decode
   ////////////////////////////////////////////////////////////////////////////

   // Microword load, dispatch load, or cache sweep
   assign loadEn = vmaBus.loadStrobe &
                   ((vmaBus.cmd.cycle & vmaBus.cmd.loadVma) |
                    (vmaBus.cmd.cycle & vmaBus.cmd.aRead & vmaBus.cmd.dispVma) |
                    vmaBus.cmd.clrCache);

   // User space unless forced to exec, or previous context is user
   assign userNext = (~vmaBus.cmd.forceExec & pcFlags.user & ~cpuExec) |
                     (vmaBus.cmd.fetchCycle & pcFlags.user) |
                     ((prevEn | vmaBus.cmd.selPrevious) & pcFlags.prevUser) |
                     vmaBus.cmd.forceUser;

   ////////////////////////////////////////////////////////////////////////////
   // Address and flag registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         addrReg     <= '0;
         vmaSweep    <= 1'b0;
         vmaExtended <= 1'b0;
         user        <= 1'b0;
         fetch       <= 1'b0;
         physical    <= 1'b0;
         previous    <= 1'b0;
         ioCycle     <= 1'b0;
         wruCycle    <= 1'b0;
         vectorCycle <= 1'b0;
         ioByteCycle <= 1'b0;
      end
      else if (loadEn)
      begin
         // Address is the right-hand end of the word
         addrReg     <= dp[memPkg::dataWidth-addrWidth +: addrWidth];
         vmaSweep    <= vmaBus.cmd.clrCache;
         vmaExtended <= vmaBus.cmd.extAddr;
         if (vmaBus.cmd.dpFunc)
         begin
            // Flags straight from the left half of the word
            user        <= dp[memPkg::flagUser];
            fetch       <= dp[memPkg::flagFetch];
            physical    <= dp[memPkg::flagPhysical];
            previous    <= dp[memPkg::flagPrevious];
            ioCycle     <= dp[memPkg::flagIo];
            wruCycle    <= dp[memPkg::flagWru];
            vectorCycle <= dp[memPkg::flagVector];
            ioByteCycle <= dp[memPkg::flagIoByte];
         end
         else
         begin
            user        <= userNext;
            fetch       <= vmaBus.cmd.fetchCycle;
            physical    <= vmaBus.cmd.physical;
            previous    <= prevEn | vmaBus.cmd.selPrevious;
            // No I/O from the microword path
            ioCycle     <= 1'b0;
            wruCycle    <= 1'b0;
            vectorCycle <= 1'b0;
            ioByteCycle <= 1'b0;
         end
      end
   end

   // Flags word, cycle bits come from the cycle register
   always_comb
   begin
      flags = '0;
      flags[memPkg::flagUser]     = user;
      flags[memPkg::flagFetch]    = fetch;
      flags[memPkg::flagRead]     = vmaBus.rdCycle;
      flags[memPkg::flagWrTest]   = vmaBus.wrTestCycle;
      flags[memPkg::flagWrite]    = vmaBus.wrCycle;
      flags[memPkg::flagCacheInh] = vmaBus.cacheInh;
      flags[memPkg::flagPhysical] = physical;
      flags[memPkg::flagPrevious] = previous;
      flags[memPkg::flagIo]       = ioCycle;
      flags[memPkg::flagWru]      = wruCycle;
      flags[memPkg::flagVector]   = vectorCycle;
      flags[memPkg::flagIoByte]   = ioByteCycle;
   end

   assign vmaBus.vmaAddr  = addrReg;
   assign vmaBus.vmaFlags = flags;

endmodule

`default_nettype wire

// ==== verilog/cycleSelect.sv ====
// Memory cycle type register
// Write data register

`default_nettype none

module cycleSelect
(
   input  wire logic                         clk,
   input  wire logic                         rst,
   vmaIf.cycle                               cycleBus,
   input  wire logic [0:memPkg::dataWidth-1] dp
);

   logic loadEn;
   logic rdReg;
   logic wrTestReg;
   logic wrReg;
   logic cacheInhReg;
   logic [0:memPkg::dataWidth-1] dataReg;

   // Any memory function loads the cycle type
   assign loadEn = cycleBus.loadStrobe & cycleBus.cmd.cycle;

   ////////////////////////////////////////////////////////////////////////////
   // Cycle type select
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rdReg       <= 1'b0;
         wrTestReg   <= 1'b0;
         wrReg       <= 1'b0;
         cacheInhReg <= 1'b0;
         dataReg     <= '0;
      end
      else if (loadEn)
      begin
         dataReg <= dp;
         if (cycleBus.cmd.aRead)
         begin
            if (cycleBus.cmd.dpFunc)
            begin
               // Dispatch overridden, no memory cycle
               rdReg       <= 1'b0;
               wrTestReg   <= 1'b0;
               wrReg       <= 1'b0;
               cacheInhReg <= 1'b0;
            end
            else
            begin
               // Type from dispatch ROM, never cache inhibit
               rdReg       <= cycleBus.cmd.dispRead;
               wrTestReg   <= cycleBus.cmd.dispWrTest;
               wrReg       <= cycleBus.cmd.dispWrite;
               cacheInhReg <= 1'b0;
            end
         end
         else if (cycleBus.cmd.dpFunc)
         begin
            // Same bit positions as the flags word
            rdReg       <= dp[memPkg::flagRead];
            wrTestReg   <= dp[memPkg::flagWrTest];
            wrReg       <= dp[memPkg::flagWrite];
            cacheInhReg <= dp[memPkg::flagCacheInh];
         end
         else
         begin
            rdReg       <= cycleBus.cmd.readCycle;
            wrTestReg   <= cycleBus.cmd.wrTestCycle;
            wrReg       <= cycleBus.cmd.writeCycle;
            cacheInhReg <= cycleBus.cmd.cacheInh;
         end
      end
   end

   assign cycleBus.rdCycle     = rdReg;
   assign cycleBus.wrTestCycle = wrTestReg;
   assign cycleBus.wrCycle     = wrReg;
   assign cycleBus.cacheInh    = cacheInhReg;
   assign cycleBus.writeData   = dataReg;

endmodule

`default_nettype wire

// ==== verilog/memControl.sv ====
// Command handshake and load strobe
// Bus cycle FSM, Wishbone classic master
// Read data return

`default_nettype none

module memControl #(
   parameter int addrWidth = memPkg::addrWidth
)
(
   input  wire logic                         clk,
   input  wire logic                         rst,
   input  wire logic                         cmdValid,
   output logic                              cmdReady,
   input  wire memPkg::memCmd_t              cmd,
   vmaIf.ctrl                                ctrlBus,
   output logic                              wbCyc,
   output logic                              wbStb,
   output logic                              wbWe,
   output logic [addrWidth-1:0]              wbAdr,
   output logic [0:memPkg::dataWidth-1]      wbDatO,
   input  wire logic [0:memPkg::dataWidth-1] wbDatI,
   input  wire logic                         wbAck,
   output logic [0:memPkg::dataWidth-1]      readData,
   output logic                              readValid
);

   typedef enum logic [1:0] {
      idle,
      busCycle,
      done
   } state_t;

   state_t state;
   logic pending;
   logic readCyc;
   logic busNeed;
   logic accept;

   ////////////////////////////////////////////////////////////////////////////
   // Command acceptance
   ////////////////////////////////////////////////////////////////////////////

   // Stored cycle bits ask for a bus transfer
   assign busNeed = ctrlBus.rdCycle | ctrlBus.wrTestCycle | ctrlBus.wrCycle;

   // Busy while a transfer is being decided or is on the bus
   assign cmdReady = (state != busCycle) & ~(pending & busNeed);
   assign accept   = cmdValid & cmdReady;

   // Datapath registers load on the accept edge
   assign ctrlBus.cmd        = cmd;
   assign ctrlBus.loadStrobe = accept;

   ////////////////////////////////////////////////////////////////////////////
   // Bus cycle FSM
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state   <= idle;
         pending <= 1'b0;
         readCyc <= 1'b0;
      end
      else
      begin
         case (state)
            idle, done:
            begin
               if (pending & busNeed)
               begin
                  // Start bus cycle
                  // Read takes priority over write
                  state   <= busCycle;
                  pending <= 1'b0;
                  readCyc <= ctrlBus.rdCycle | ctrlBus.wrTestCycle;
               end
               else
               begin
                  state   <= idle;
                  // Decide next cycle once cycle bits are stored
                  pending <= accept & cmd.cycle;
               end
            end
            busCycle:
            begin
               // Wait states until the slave acks
               if (wbAck)
               begin
                  state <= done;
               end
            end
            default:
            begin
               state <= idle;
            end
         endcase
      end
   end

   // Read data captured at the ack edge
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         readData <= '0;
      end
      else if ((state == busCycle) && wbAck && readCyc)
      begin
         readData <= wbDatI;
      end
   end

   // Single strobe and no bursts
   assign wbCyc     = (state == busCycle);
   assign wbStb     = (state == busCycle);
   assign wbWe      = (state == busCycle) & ~readCyc;
   assign wbAdr     = ctrlBus.vmaAddr;
   assign wbDatO    = ctrlBus.writeData;
   assign readValid = (state == done) & readCyc;

endmodule

`default_nettype wire

// ==== verilog/memUnit.sv ====
// Memory reference front end, top level
// Controller, VMA register and cycle register joined by one vmaIf

`default_nettype none

module memUnit #(
   parameter int addrWidth = memPkg::addrWidth
)
(
   input  wire logic                         clk,
   input  wire logic                         rst,
   // Command port
   input  wire logic                         cmdValid,
   output logic                              cmdReady,
   input  wire memPkg::memCmd_t              cmd,
   input  wire logic [0:memPkg::dataWidth-1] dp,
   input  wire memPkg::pcFlags_t             pcFlags,
   input  wire logic                         cpuExec,
   input  wire logic                         prevEn,
   // Wishbone master
   output logic                              wbCyc,
   output logic                              wbStb,
   output logic                              wbWe,
   output logic [addrWidth-1:0]              wbAdr,
   output logic [0:memPkg::dataWidth-1]      wbDatO,
   input  wire logic [0:memPkg::dataWidth-1] wbDatI,
   input  wire logic                         wbAck,
   // Read return
   output logic [0:memPkg::dataWidth-1]      readData,
   output logic                              readValid,
   // VMA state
   output logic                              vmaSweep,
   output logic                              vmaExtended,
   output logic [addrWidth-1:0]              vmaAddr,
   output logic [0:memPkg::flagWidth-1]      vmaFlags
);

   vmaIf #(.addrWidth(addrWidth)) vmaBus ();

   memControl #(.addrWidth(addrWidth)) memControl_inst (
      .clk       (clk),
      .rst       (rst),
      .cmdValid  (cmdValid),
      .cmdReady  (cmdReady),
      .cmd       (cmd),
      .ctrlBus   (vmaBus.ctrl),
      .wbCyc     (wbCyc),
      .wbStb     (wbStb),
      .wbWe      (wbWe),
      .wbAdr     (wbAdr),
      .wbDatO    (wbDatO),
      .wbDatI    (wbDatI),
      .wbAck     (wbAck),
      .readData  (readData),
      .readValid (readValid)
   );

   vmaRegister #(.addrWidth(addrWidth)) vmaRegister_inst (
      .clk         (clk),
      .rst         (rst),
      .vmaBus      (vmaBus.vma),
      .dp          (dp),
      .pcFlags     (pcFlags),
      .cpuExec     (cpuExec),
      .prevEn      (prevEn),
      .vmaSweep    (vmaSweep),
      .vmaExtended (vmaExtended)
   );

   cycleSelect cycleSelect_inst (
      .clk      (clk),
      .rst      (rst),
      .cycleBus (vmaBus.cycle),
      .dp       (dp)
   );

   // VMA visible outside for paging
   assign vmaAddr  = vmaBus.vmaAddr;
   assign vmaFlags = vmaBus.vmaFlags;

endmodule

`default_nettype wire

// ==== dv/memModel.sv ====
// Wishbone classic slave memory for the testbench
// 64 words, ack delayed by a stall count

`default_nettype none

module memModel #(
   parameter int addrWidth = memPkg::addrWidth,
   parameter int depth     = 64
)
(
   input  wire logic                         clk,
   input  wire logic                         rst,
   input  wire logic [1:0]                   stall,
   input  wire logic                         cyc,
   input  wire logic                         stb,
   input  wire logic                         we,
   input  wire logic [addrWidth-1:0]         adr,
   input  wire logic [0:memPkg::dataWidth-1] datI,
   output logic [0:memPkg::dataWidth-1]      datO,
   output logic                              ack
);

   localparam int idxWidth = $clog2(depth);

   logic [0:memPkg::dataWidth-1] mem [depth];
   logic [1:0] waitCount;
   logic [idxWidth-1:0] idx;

   // Word select, upper address bits ignored
   assign idx = adr[idxWidth-1:0];

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ack       <= 1'b0;
         waitCount <= 2'd0;
         datO      <= '0;
         // Fill pattern follows the word address
         for (int i = 0; i < depth; i++)
         begin
            mem[i] <= {4'(i), 32'(i) * 32'h9E3779B1};
         end
      end
      else if (ack)
      begin
         // Master drops cyc on the same edge
         ack       <= 1'b0;
         waitCount <= 2'd0;
      end
      else if (cyc & stb)
      begin
         if (waitCount == stall)
         begin
            ack <= 1'b1;
            if (we)
            begin
               mem[idx] <= datI;
            end
            else
            begin
               datO <= mem[idx];
            end
         end
         else
         begin
            // Wait state
            waitCount <= waitCount + 2'd1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== dv/memUnitTb.sv ====
// Testbench for the memory front end
// Clock, reset, stimulus table and the checks on it
// Random ack stalls, timeout and summary

`default_nettype none

module memUnitTb;

   localparam int addrWidth     = memPkg::addrWidth;
   localparam int numTests      = 18;
   localparam int resetCycles   = 8;
   localparam int timeoutCycles = numTests * 10 + resetCycles;

   localparam logic [1:0] busNone  = 2'd0;
   localparam logic [1:0] busRead  = 2'd1;
   localparam logic [1:0] busWrite = 2'd2;

   typedef struct packed {
      memPkg::memCmd_t cmd;
      logic [0:memPkg::dataWidth-1] dp;
      memPkg::pcFlags_t pc;
      logic cpuExec;
      logic prevEn;
      logic [addrWidth-1:0] expAddr;
      logic [0:memPkg::flagWidth-1] expFlags;
      logic [1:0] expBus;
      logic [0:memPkg::dataWidth-1] expData;
      logic expSweep;
      logic expExt;
   } testEntry_t;

   logic clk;
   logic rst;
   logic cmdValid;
   logic cmdReady;
   memPkg::memCmd_t cmd;
   logic [0:memPkg::dataWidth-1] dp;
   memPkg::pcFlags_t pcFlags;
   logic cpuExec;
   logic prevEn;
   logic wbCyc;
   logic wbStb;
   logic wbWe;
   logic [addrWidth-1:0] wbAdr;
   logic [0:memPkg::dataWidth-1] wbDatO;
   logic [0:memPkg::dataWidth-1] wbDatI;
   logic wbAck;
   logic [0:memPkg::dataWidth-1] readData;
   logic readValid;
   logic vmaSweep;
   logic vmaExtended;
   logic [addrWidth-1:0] vmaAddr;
   logic [0:memPkg::flagWidth-1] vmaFlags;
   logic [1:0] stallCycles;

   testEntry_t tests [numTests];
   int entryCount = 0;
   int errorCount = 0;
   int passCount  = 0;
   int failCount  = 0;
   int cycleCount = 0;
   logic [31:0] rngState = 32'd35374;

   memUnit #(.addrWidth(addrWidth)) memUnit_inst (
      .clk(clk), .rst(rst), .cmdValid(cmdValid), .cmdReady(cmdReady), .cmd(cmd),
      .dp(dp), .pcFlags(pcFlags), .cpuExec(cpuExec), .prevEn(prevEn),
      .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatO(wbDatO),
      .wbDatI(wbDatI), .wbAck(wbAck), .readData(readData), .readValid(readValid),
      .vmaSweep(vmaSweep), .vmaExtended(vmaExtended), .vmaAddr(vmaAddr),
      .vmaFlags(vmaFlags)
   );

   memModel #(.addrWidth(addrWidth)) memModel_inst (
      .clk(clk), .rst(rst), .stall(stallCycles), .cyc(wbCyc), .stb(wbStb), .we(wbWe),
      .adr(wbAdr), .datI(wbDatO), .datO(wbDatI), .ack(wbAck)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Clock and timeout
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= timeoutCycles)
      begin
         $display("Timeout: the tests did not finish within %0d cycles", timeoutCycles);
         $display("test failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Flags word from its named bits with bits 1 and 6 at zero
   function automatic logic [0:memPkg::flagWidth-1] makeFlags(
      input logic user, fetch, rd, wrTest, wr, cacheInh,
      input logic phys, prev, io, wru, vector, ioByte);
      logic [0:memPkg::flagWidth-1] f;
      f = '0;
      f[memPkg::flagUser]     = user;
      f[memPkg::flagFetch]    = fetch;
      f[memPkg::flagRead]     = rd;
      f[memPkg::flagWrTest]   = wrTest;
      f[memPkg::flagWrite]    = wr;
      f[memPkg::flagCacheInh] = cacheInh;
      f[memPkg::flagPhysical] = phys;
      f[memPkg::flagPrevious] = prev;
      f[memPkg::flagIo]       = io;
      f[memPkg::flagWru]      = wru;
      f[memPkg::flagVector]   = vector;
      f[memPkg::flagIoByte]   = ioByte;
      return f;
   endfunction

   // Flag field on the left and address on the right
   function automatic logic [0:memPkg::dataWidth-1] dpWord(
      input logic [0:memPkg::flagWidth-1] f, input logic [addrWidth-1:0] a);
      return {f, a};
   endfunction

   // Plain microword VMA load
   function automatic memPkg::memCmd_t microCmd(
      input logic rd, wrTest, wr, cacheInh, fetch, phys, forceUser, forceExec, selPrev);
      memPkg::memCmd_t c;
      c = '0;
      c.cycle = 1'b1;
      c.loadVma = 1'b1;
      c.readCycle = rd;
      c.wrTestCycle = wrTest;
      c.writeCycle = wr;
      c.cacheInh = cacheInh;
      c.fetchCycle = fetch;
      c.physical = phys;
      c.forceUser = forceUser;
      c.forceExec = forceExec;
      c.selPrevious = selPrev;
      return c;
   endfunction

   // Same command with the extended address request
   function automatic memPkg::memCmd_t withExtAddr(input memPkg::memCmd_t c);
      memPkg::memCmd_t e;
      e = c;
      e.extAddr = 1'b1;
      return e;
   endfunction

   function automatic memPkg::memCmd_t dpCmd();
      memPkg::memCmd_t c;
      c = '0;
      c.cycle = 1'b1;
      c.loadVma = 1'b1;
      c.dpFunc = 1'b1;
      return c;
   endfunction

   // Dispatch load with the microword read bit set so the dispatch choice shows
   function automatic memPkg::memCmd_t dispCmd(
      input logic rd, wrTest, wr, vma, dpFunc);
      memPkg::memCmd_t c;
      c = '0;
      c.cycle = 1'b1;
      c.aRead = 1'b1;
      c.readCycle = 1'b1;
      c.dispRead = rd;
      c.dispWrTest = wrTest;
      c.dispWrite = wr;
      c.dispVma = vma;
      c.dpFunc = dpFunc;
      return c;
   endfunction

   function automatic memPkg::memCmd_t sweepCmd();
      memPkg::memCmd_t c;
      c = '0;
      c.clrCache = 1'b1;
      return c;
   endfunction

   function automatic string busName(input logic [1:0] bus);
      if (bus == busRead)
      begin
         return "read";
      end
      else if (bus == busWrite)
      begin
         return "write";
      end
      return "no bus";
   endfunction

   task automatic addEntry(
      input memPkg::memCmd_t c, input logic [0:memPkg::dataWidth-1] d,
      input logic user, prevUser, exec, prev,
      input logic [addrWidth-1:0] addr, input logic [0:memPkg::flagWidth-1] flags,
      input logic [1:0] bus, input logic [0:memPkg::dataWidth-1] data,
      input logic sweep, ext);
      tests[entryCount] = {c, d, user, prevUser, exec, prev, addr, flags, bus, data, sweep, ext};
      entryCount++;
   endtask

   task automatic nextCycle();
      @(posedge clk);
      #1;
   endtask

   task automatic checkValue(input string what, input logic [35:0] got,
                             input logic [35:0] expected);
      assert (got === expected)
      else
      begin
         $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, expected);
         errorCount++;
      end
   endtask

   task automatic checkVma(input testEntry_t t);
      checkValue("vmaAddr", 36'(vmaAddr), 36'(t.expAddr));
      checkValue("vmaFlags", 36'(vmaFlags), 36'(t.expFlags));
      checkValue("vmaSweep", 36'(vmaSweep), 36'(t.expSweep));
      checkValue("vmaExtended", 36'(vmaExtended), 36'(t.expExt));
   endtask

   task automatic reportTest(input string name, input int errorsBefore);
      if (errorCount == errorsBefore)
      begin
         passCount++;
         $display("Test %s: ok", name);
      end
      else
      begin
         failCount++;
         $display("Test %s: FAIL", name);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus table
   ////////////////////////////////////////////////////////////////////////////

   task automatic buildTable();
      logic [0:memPkg::dataWidth-1] wd0;
      logic [0:memPkg::dataWidth-1] wd1;
      logic [0:memPkg::dataWidth-1] wd2;
      logic [0:memPkg::flagWidth-1] zf;
      wd0 = dpWord(14'h2A5C, 22'h000005);
      wd1 = dpWord(14'h1337, 22'h3C0011);
      wd2 = dpWord(14'h0C3A, 22'h000021);
      zf  = '0;
      // User rule across pc, exec, force and previous inputs
      addEntry(microCmd(0,0,0,0,0,0,0,0,0), dpWord(zf, 22'h123456), 1, 0, 0, 0,
               22'h123456, makeFlags(1,0,0,0,0,0,0,0,0,0,0,0), busNone, '0, 0, 0);
      addEntry(microCmd(0,0,0,0,0,0,0,0,0), dpWord(zf, 22'h0BCDEF), 1, 0, 1, 0,
               22'h0BCDEF, zf, busNone, '0, 0, 0);
      addEntry(microCmd(0,0,0,0,1,0,0,1,0), dpWord(zf, 22'h000040), 1, 0, 0, 0,
               22'h000040, makeFlags(1,1,0,0,0,0,0,0,0,0,0,0), busNone, '0, 0, 0);
      addEntry(microCmd(0,0,0,0,0,0,0,1,0), dpWord(zf, 22'h000041), 1, 0, 0, 0,
               22'h000041, zf, busNone, '0, 0, 0);
      addEntry(microCmd(0,0,0,0,0,0,0,0,0), dpWord(zf, 22'h000042), 0, 1, 0, 1,
               22'h000042, makeFlags(1,0,0,0,0,0,0,1,0,0,0,0), busNone, '0, 0, 0);
      addEntry(microCmd(0,0,0,0,0,0,0,0,1), dpWord(zf, 22'h000043), 0, 0, 0, 0,
               22'h000043, makeFlags(0,0,0,0,0,0,0,1,0,0,0,0), busNone, '0, 0, 0);
      addEntry(withExtAddr(microCmd(0,0,0,0,0,1,1,0,0)), dpWord(zf, 22'h000044), 0, 0, 1, 0,
               22'h000044, makeFlags(1,0,0,0,0,0,1,0,0,0,0,0), busNone, '0, 0, 1);
      // Writes and then reads back under random stalls
      addEntry(microCmd(0,0,1,0,0,0,0,0,0), wd0, 0, 0, 0, 0,
               22'h000005, makeFlags(0,0,0,0,1,0,0,0,0,0,0,0), busWrite, wd0, 0, 0);
      addEntry(microCmd(0,0,1,0,0,0,0,0,0), wd1, 0, 0, 0, 0,
               22'h3C0011, makeFlags(0,0,0,0,1,0,0,0,0,0,0,0), busWrite, wd1, 0, 0);
      addEntry(microCmd(1,0,0,0,0,0,0,0,0), dpWord(zf, 22'h000005), 0, 0, 0, 0,
               22'h000005, makeFlags(0,0,1,0,0,0,0,0,0,0,0,0), busRead, wd0, 0, 0);
      addEntry(microCmd(0,1,0,1,0,0,0,0,0), dpWord(zf, 22'h3C0011), 0, 0, 0, 0,
               22'h3C0011, makeFlags(0,0,0,1,0,1,0,0,0,0,0,0), busRead, wd1, 0, 0);
      // Flags from the word with bits 1 and 6 set in dp but not kept
      addEntry(dpCmd(), dpWord(14'b11100011101010, 22'h2AAAAA), 0, 0, 1, 0,
               22'h2AAAAA, makeFlags(1,1,0,0,0,1,1,0,1,0,1,0), busNone, '0, 0, 0);
      addEntry(dpCmd(), dpWord(14'b00010000010101, 22'h000005), 0, 0, 0, 0,
               22'h000005, makeFlags(0,0,1,0,0,0,0,1,0,1,0,1), busRead, wd0, 0, 0);
      // Dispatch cycle type
      addEntry(dispCmd(0,0,1,1,0), wd2, 0, 0, 0, 0,
               22'h000021, makeFlags(0,0,0,0,1,0,0,0,0,0,0,0), busWrite, wd2, 0, 0);
      addEntry(dispCmd(1,0,0,1,0), dpWord(zf, 22'h000021), 0, 0, 0, 0,
               22'h000021, makeFlags(0,0,1,0,0,0,0,0,0,0,0,0), busRead, wd2, 0, 0);
      // VMA untouched and cycle bits cleared
      addEntry(dispCmd(1,1,1,0,1), dpWord(14'h3FFF, 22'h155555), 0, 0, 0, 0,
               22'h000021, zf, busNone, '0, 0, 0);
      // Sweep and an ordinary load that clears it
      addEntry(sweepCmd(), dpWord(zf, 22'h0F0F0F), 1, 0, 0, 0,
               22'h0F0F0F, makeFlags(1,0,0,0,0,0,0,0,0,0,0,0), busNone, '0, 1, 0);
      addEntry(microCmd(0,0,0,0,0,0,0,0,0), dpWord(zf, 22'h000100), 0, 0, 0, 0,
               22'h000100, zf, busNone, '0, 0, 0);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   task automatic checkReset();
      int errorsBefore;
      errorsBefore = errorCount;
      checkValue("vmaAddr", 36'(vmaAddr), 36'd0);
      checkValue("vmaFlags", 36'(vmaFlags), 36'd0);
      checkValue("vmaSweep", 36'(vmaSweep), 36'd0);
      checkValue("vmaExtended", 36'(vmaExtended), 36'd0);
      checkValue("wbCyc", 36'(wbCyc), 36'd0);
      checkValue("wbStb", 36'(wbStb), 36'd0);
      checkValue("wbWe", 36'(wbWe), 36'd0);
      checkValue("readValid", 36'(readValid), 36'd0);
      checkValue("cmdReady", 36'(cmdReady), 36'd1);
      reportTest("reset", errorsBefore);
   endtask

   task automatic runEntry(input int idx);
      testEntry_t t;
      int errorsBefore;
      t = tests[idx];
      errorsBefore = errorCount;
      rngState = xorshift32(rngState);
      stallCycles = rngState[1:0];
      while (!cmdReady)
      begin
         nextCycle();
      end
      cmdValid = 1'b1;
      cmd      = t.cmd;
      dp       = t.dp;
      pcFlags  = t.pc;
      cpuExec  = t.cpuExec;
      prevEn   = t.prevEn;
      // Accept edge
      nextCycle();
      cmdValid = 1'b0;
      if (t.expBus == busNone)
      begin
         checkVma(t);
         checkValue("cmdReady", 36'(cmdReady), 36'd1);
         repeat (2)
         begin
            checkValue("wbCyc", 36'(wbCyc), 36'd0);
            checkValue("readValid", 36'(readValid), 36'd0);
            nextCycle();
         end
      end
      else
      begin
         while (!wbCyc)
         begin
            checkValue("cmdReady before bus cycle", 36'(cmdReady), 36'd0);
            nextCycle();
         end
         checkVma(t);
         checkValue("wbWe", 36'(wbWe), 36'(t.expBus == busWrite));
         checkValue("wbAdr", 36'(wbAdr), 36'(t.expAddr));
         if (t.expBus == busWrite)
         begin
            checkValue("wbDatO", wbDatO, t.expData);
         end
         // Held until the ack edge
         while (wbCyc)
         begin
            checkValue("cmdReady in bus cycle", 36'(cmdReady), 36'd0);
            checkValue("wbStb", 36'(wbStb), 36'd1);
            nextCycle();
         end
         checkValue("cmdReady after ack", 36'(cmdReady), 36'd1);
         checkValue("readValid", 36'(readValid), 36'(t.expBus == busRead));
         if (t.expBus == busRead)
         begin
            checkValue("readData", readData, t.expData);
         end
         else
         begin
            checkValue("stored word", memModel_inst.mem[t.expAddr[5:0]], t.expData);
         end
      end
      reportTest($sformatf("%0d %s", idx, busName(t.expBus)), errorsBefore);
   endtask

   initial
   begin
      rst         = 1'b1;
      cmdValid    = 1'b0;
      cmd         = '0;
      dp          = '0;
      pcFlags     = '0;
      cpuExec     = 1'b0;
      prevEn      = 1'b0;
      stallCycles = 2'd0;
      buildTable();
      repeat (resetCycles) @(posedge clk);
      #1;
      rst = 1'b0;
      checkReset();
      for (int i = 0; i < numTests; i++)
      begin
         runEntry(i);
      end
      $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
               passCount + failCount, passCount, failCount, errorCount);
      if (errorCount == 0)
      begin
         $display("test passed");
      end
      else
      begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/memPkg.sv
verilog/memIf.sv
verilog/vmaRegister.sv
verilog/cycleSelect.sv
verilog/memControl.sv
verilog/memUnit.sv
dv/memModel.sv
dv/memUnitTb.sv

// ==== Makefile ====
# Verilator build for the memory front end testbench

VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = memUnitTb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# Pass only when the log holds the pass line
sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
